//--- compile.f
hdl/la_backend_pkg.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/wb_stage.sv
hdl/wb_backend_top.sv
verif/wb_backend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the write-back backend testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module wb_backend_tb -Mdir "$build_dir" -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vwb_backend_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
exit 0

//--- verif/wb_backend_tb.sv
`timescale 1ns/1ps

module wb_backend_tb
    import la_backend_pkg::*;
();

    typedef struct {
        string                name;
        mem_to_wb_t           item;
        logic                 offer_next;   // extra item in the following cycle
        trace_t               exp_trace;
        logic                 exp_flush;
        logic [xlen-1:0]      exp_flush_pc;
        logic [rf_addr_w-1:0] chk_reg;
        logic [xlen-1:0]      chk_val;
        logic [rf_addr_w-1:0] chk_reg2;     // read on the second port
        logic [xlen-1:0]      chk_val2;
    } vector_t;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 mem_to_wb_valid;
    mem_to_wb_t           mem_to_wb_bus;
    logic                 wb_allowin;
    logic [rf_addr_w-1:0] raddr1;
    logic [rf_addr_w-1:0] raddr2;
    logic [xlen-1:0]      rdata1;
    logic [xlen-1:0]      rdata2;
    trace_t               trace;
    logic                 flush_valid;
    logic [xlen-1:0]      flush_pc;

    vector_t              vectors[$];
    mem_to_wb_t           discard_item;  // must never commit
    logic                 table_ready = 1'b0;
    logic [31:0]          lfsr;
    logic [xlen-1:0]      next_pc;
    logic [rf_addr_w-1:0] prev_rd;       // last nonzero register the model committed
    int                   errors;
    int                   checks;

    // reference model state
    logic [xlen-1:0] m_csr [logic [13:0]];
    logic [xlen-1:0] m_rf [rf_depth];

    wb_backend_top UUT (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .wb_allowin      (wb_allowin),
        .raddr1          (raddr1),
        .raddr2          (raddr2),
        .rdata1          (rdata1),
        .rdata2          (rdata2),
        .trace           (trace),
        .flush_valid     (flush_valid),
        .flush_pc        (flush_pc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [xlen-1:0] rand_word();
        logic [xlen-1:0] w;
        w = '0;
        for (int i = 0; i < xlen; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[xlen-2:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic mem_to_wb_t base_item(input logic [rf_addr_w-1:0] rd);
        mem_to_wb_t it;
        it = '0;
        it.pc = next_pc;
        it.rf_we = 1'b1;
        it.rf_waddr = rd;
        next_pc = next_pc + 32'd4;
        return it;
    endfunction

    // csrrd and csrwr both return the old value to rd
    function automatic mem_to_wb_t csr_item(input logic [rf_addr_w-1:0] rd, input csr_num_e num,
                                            input logic we, input logic [xlen-1:0] mask,
                                            input logic [xlen-1:0] value);
        mem_to_wb_t it;
        it = base_item(rd);
        it.csr_re = 1'b1;
        it.csr_we = we;
        it.csr_num = num;
        it.csr_wmask = mask;
        it.csr_wvalue = value;
        return it;
    endfunction

    // run the reference model on one item and queue it with its expected results
    task automatic add_vector(input string name, input mem_to_wb_t it, input logic offer,
                              input logic [rf_addr_w-1:0] chk_reg);
        vector_t         v;
        logic [xlen-1:0] old_csr;
        logic [xlen-1:0] rd_val;
        logic [5:0]      code;
        v.name = name;
        v.item = it;
        v.offer_next = offer;
        old_csr = m_csr.exists(it.csr_num) ? m_csr[it.csr_num] : '0;
        if (it.csr_re) begin
            rd_val = old_csr;
        end else if (it.read_tid) begin
            rd_val = m_csr[csr_tid];
        end else begin
            rd_val = it.rf_wdata;
        end
        v.exp_trace.pc = it.pc;
        v.exp_trace.rf_we = 4'h0;
        v.exp_trace.rf_wnum = it.rf_waddr;
        v.exp_trace.rf_wdata = rd_val;
        v.exp_flush = 1'b0;
        v.exp_flush_pc = '0;
        if (it.excp != '0) begin
            code = it.excp.adef ? 6'd8 : it.excp.sys ? 6'd11 : it.excp.brk ? 6'd12 :
                   it.excp.ine ? 6'd13 : 6'd9;
            v.exp_flush = 1'b1;
            v.exp_flush_pc = m_csr[csr_eentry];
            m_csr[csr_prmd] = (m_csr[csr_prmd] & ~32'h7) | (m_csr[csr_crmd] & 32'h7);
            m_csr[csr_crmd] = m_csr[csr_crmd] & ~32'h7;  // plv 0, ie 0
            m_csr[csr_era] = it.pc;
            m_csr[csr_estat] = (m_csr[csr_estat] & ~32'h7fff_0000) | (32'(code) << 16) |
                               (32'(it.esubcode) << 22);
        end else if (it.ertn) begin
            v.exp_flush = 1'b1;
            v.exp_flush_pc = m_csr[csr_era];
            m_csr[csr_crmd] = (m_csr[csr_crmd] & ~32'h7) | (m_csr[csr_prmd] & 32'h7);
        end else begin
            if (it.csr_we && m_csr.exists(it.csr_num)) begin
                m_csr[it.csr_num] = (old_csr & ~it.csr_wmask) | (it.csr_wvalue & it.csr_wmask);
            end
            if (it.rf_we) begin
                v.exp_trace.rf_we = 4'hf;
                if (it.rf_waddr != '0) begin
                    m_rf[it.rf_waddr] = rd_val;
                end
            end
        end
        v.chk_reg = chk_reg;
        v.chk_val = m_rf[chk_reg];
        v.chk_reg2 = prev_rd;
        v.chk_val2 = m_rf[prev_rd];
        if (v.exp_trace.rf_we != 4'h0 && it.rf_waddr != '0) begin
            prev_rd = it.rf_waddr;
        end
        vectors.push_back(v);
    endtask

    task automatic build_table();
        mem_to_wb_t it;
        lfsr = 32'hec16;
        next_pc = 32'h1c00_0000;
        prev_rd = '0;
        m_csr[csr_crmd] = 32'h0000_0008;
        m_csr[csr_prmd] = '0;
        m_csr[csr_estat] = '0;
        m_csr[csr_era] = '0;
        m_csr[csr_eentry] = 32'h1c00_8000;
        m_csr[csr_save0] = '0;
        m_csr[csr_save1] = '0;
        m_csr[csr_save2] = '0;
        m_csr[csr_save3] = '0;
        m_csr[csr_tid] = 32'h0000_00a5;
        foreach (m_rf[i]) begin
            m_rf[i] = '0;
        end
        it = base_item(5'd3);
        it.rf_wdata = rand_word();
        add_vector("alu write r3", it, 1'b0, 5'd3);
        it = base_item(5'd0);
        it.rf_wdata = rand_word();
        add_vector("alu write r0", it, 1'b0, 5'd0);
        it = base_item(5'd20);
        it.rf_wdata = rand_word();
        add_vector("alu write r20", it, 1'b0, 5'd20);
        add_vector("csrwr save0 full", csr_item(5'd4, csr_save0, 1'b1, '1, rand_word()),
                   1'b0, 5'd4);
        add_vector("csrwr save0 masked",
                   csr_item(5'd5, csr_save0, 1'b1, 32'h00ff_ff00, rand_word()), 1'b0, 5'd5);
        add_vector("csrrd save0", csr_item(5'd6, csr_save0, 1'b0, '0, '0), 1'b0, 5'd6);
        it = base_item(5'd7);
        it.read_tid = 1'b1;
        it.rf_wdata = rand_word();  // tid must win over this
        add_vector("rdcntid", it, 1'b0, 5'd7);
        add_vector("csrwr crmd plv ie", csr_item(5'd8, csr_crmd, 1'b1, 32'h7, 32'h7), 1'b0, 5'd8);
        it = base_item(5'd9);
        it.rf_wdata = rand_word();
        it.excp.sys = 1'b1;
        add_vector("syscall", it, 1'b1, 5'd20);
        discard_item = base_item(5'd20);
        discard_item.rf_wdata = rand_word();
        add_vector("csrrd era", csr_item(5'd10, csr_era, 1'b0, '0, '0), 1'b0, 5'd10);
        add_vector("csrrd estat", csr_item(5'd11, csr_estat, 1'b0, '0, '0), 1'b0, 5'd11);
        add_vector("csrrd crmd after trap", csr_item(5'd12, csr_crmd, 1'b0, '0, '0), 1'b0, 5'd12);
        add_vector("csrwr prmd", csr_item(5'd13, csr_prmd, 1'b1, 32'h7, 32'h5), 1'b0, 5'd13);
        it = base_item(5'd0);
        it.rf_we = 1'b0;
        it.ertn = 1'b1;
        add_vector("ertn", it, 1'b1, 5'd20);
        add_vector("csrrd crmd after ertn", csr_item(5'd14, csr_crmd, 1'b0, '0, '0), 1'b0, 5'd14);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] exp_val,
                               input logic [xlen-1:0] act_val);
        checks++;
        assert (act_val === exp_val)
        else begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic run_vector(input int idx);
        vector_t v;
        int      errs_before;
        v = vectors[idx];
        errs_before = errors;
        @(negedge clk);
        mem_to_wb_valid = 1'b1;
        mem_to_wb_bus = v.item;
        @(negedge clk);  // wb cycle of the item
        check_value("trace.rf_we", 32'(v.exp_trace.rf_we), 32'(trace.rf_we));
        check_value("flush_valid", 32'(v.exp_flush), 32'(flush_valid));
        if (v.exp_trace.rf_we != 4'h0) begin
            check_value("trace.pc", v.exp_trace.pc, trace.pc);
            check_value("trace.rf_wnum", 32'(v.exp_trace.rf_wnum), 32'(trace.rf_wnum));
            check_value("trace.rf_wdata", v.exp_trace.rf_wdata, trace.rf_wdata);
        end
        if (v.exp_flush) begin
            check_value("flush_pc", v.exp_flush_pc, flush_pc);
        end
        mem_to_wb_valid = v.offer_next;
        if (v.offer_next) begin
            mem_to_wb_bus = discard_item;
        end else begin
            mem_to_wb_bus = '0;
        end
        raddr1 = v.chk_reg;
        raddr2 = v.chk_reg2;
        @(negedge clk);
        mem_to_wb_valid = 1'b0;
        mem_to_wb_bus = '0;
        check_value("trace.rf_we idle", 32'h0, 32'(trace.rf_we));
        check_value("rdata1", v.chk_val, rdata1);
        check_value("rdata2", v.chk_val2, rdata2);
        $display("test %0d %s: %s", idx, v.name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        resetn = 1'b0;
        mem_to_wb_valid = 1'b0;
        mem_to_wb_bus = '0;
        raddr1 = '0;
        raddr2 = '0;
        errors = 0;
        checks = 0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_value("wb_allowin", 32'h1, 32'(wb_allowin));
        check_value("trace.rf_we", 32'h0, 32'(trace.rf_we));
        check_value("flush_valid", 32'h0, 32'(flush_valid));
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");
        foreach (vectors[i]) begin
            run_vector(i);
        end
        $display("%0d tests, %0d checks, %0d errors", vectors.size(), checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (vectors.size() * 4 + 20) @(posedge clk);
        $display("timeout: the watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- hdl/wb_backend_top.sv
`timescale 1ns/1ps

module wb_backend_top
    import la_backend_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,

    // memory stage handshake
    input  logic                 mem_to_wb_valid,
    input  mem_to_wb_t           mem_to_wb_bus,
    output logic                 wb_allowin,

    // register file read access
    input  logic [rf_addr_w-1:0] raddr1,
    input  logic [rf_addr_w-1:0] raddr2,
    output logic [xlen-1:0]      rdata1,
    output logic [xlen-1:0]      rdata2,

    output trace_t               trace,

    // fetch redirect
    output logic                 flush_valid,
    output logic [xlen-1:0]      flush_pc
);

    rf_wr_t          rf_wr;
    csr_req_t        csr_req;
    trap_t           trap;
    logic [xlen-1:0] csr_rvalue;
    logic [xlen-1:0] tid_rvalue;

    wb_stage u_wb_stage (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .wb_allowin      (wb_allowin),
        .csr_rvalue      (csr_rvalue),
        .tid_rvalue      (tid_rvalue),
        .rf_wr           (rf_wr),
        .csr_req         (csr_req),
        .trap            (trap),
        .trace           (trace)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .resetn      (resetn),
        .csr_req     (csr_req),
        .trap        (trap),
        .csr_rvalue  (csr_rvalue),
        .tid_rvalue  (tid_rvalue),
        .flush_valid (flush_valid),
        .flush_pc    (flush_pc)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rf_wr  (rf_wr)
    );

endmodule

//--- hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage
    import la_backend_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,

    // from memory stage
    input  logic            mem_to_wb_valid,
    input  mem_to_wb_t      mem_to_wb_bus,
    output logic            wb_allowin,

    // combinational answers from the csr file
    input  logic [xlen-1:0] csr_rvalue,
    input  logic [xlen-1:0] tid_rvalue,

    output rf_wr_t          rf_wr,
    output csr_req_t        csr_req,
    output trap_t           trap,
    output trace_t          trace
);

    logic            wb_valid;
    mem_to_wb_t      wb_q;        // stage register payload
    logic            wb_excp_any;
    logic            wb_flush;
    logic [xlen-1:0] final_wdata;
    ecode_e          ecode;

    // write-back never stalls
    assign wb_allowin = 1'b1;

    assign wb_excp_any = |wb_q.excp;
    assign wb_flush    = wb_valid & (wb_excp_any | wb_q.ertn);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_flush) begin
            wb_valid <= 1'b0; // item offered now is dropped
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin && !wb_flush) begin
            wb_q <= mem_to_wb_bus;
        end
    end

    // csr read beats tid read beats alu result
    always_comb begin
        if (wb_q.csr_re) begin
            final_wdata = csr_rvalue;
        end else if (wb_q.read_tid) begin
            final_wdata = tid_rvalue;
        end else begin
            final_wdata = wb_q.rf_wdata;
        end
    end

    // priority encode the one-hot tags
    always_comb begin
        if (wb_q.excp.adef) begin
            ecode = ecode_adef;
        end else if (wb_q.excp.sys) begin
            ecode = ecode_sys;
        end else if (wb_q.excp.brk) begin
            ecode = ecode_brk;
        end else if (wb_q.excp.ine) begin
            ecode = ecode_ine;
        end else begin
            ecode = ecode_ale; // last in line, also the idle value
        end
    end

    // register write, dropped for a trapping instruction
    assign rf_wr.we    = wb_valid & wb_q.rf_we & ~wb_excp_any;
    assign rf_wr.waddr = wb_q.rf_waddr;
    assign rf_wr.wdata = final_wdata;

    assign csr_req.re     = wb_valid & wb_q.csr_re;
    assign csr_req.we     = wb_valid & wb_q.csr_we & ~wb_excp_any;
    assign csr_req.num    = wb_q.csr_num;
    assign csr_req.wmask  = wb_q.csr_wmask;
    assign csr_req.wvalue = wb_q.csr_wvalue;

    assign trap.ex       = wb_valid & wb_excp_any;
    assign trap.ecode    = ecode;
    assign trap.esubcode = wb_q.esubcode;
    assign trap.pc       = wb_q.pc;
    assign trap.ertn     = wb_valid & wb_q.ertn & ~wb_excp_any;

    // trace mirrors the committed register write
    assign trace.pc       = wb_q.pc;
    assign trace.rf_we    = {4{rf_wr.we}};
    assign trace.rf_wnum  = wb_q.rf_waddr;
    assign trace.rf_wdata = final_wdata;

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import la_backend_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,

    input  csr_req_t        csr_req,
    input  trap_t           trap,

    output logic [xlen-1:0] csr_rvalue,
    output logic [xlen-1:0] tid_rvalue,

    // fetch redirect
    output logic            flush_valid,
    output logic [xlen-1:0] flush_pc
);

    logic [xlen-1:0] crmd;
    logic [xlen-1:0] prmd;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] era;
    logic [xlen-1:0] eentry;
    logic [xlen-1:0] save [4];
    logic [xlen-1:0] tid;

    logic [xlen-1:0] rd_mux;
    logic [xlen-1:0] wr_merge;

    function automatic logic [xlen-1:0] masked_wr(
        input logic [xlen-1:0] old_val,
        input logic [xlen-1:0] wvalue,
        input logic [xlen-1:0] wmask
    );
        return (old_val & ~wmask) | (wvalue & wmask);
    endfunction

    // merged value for the selected csr
    assign wr_merge = masked_wr(rd_mux, csr_req.wvalue, csr_req.wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd   <= crmd_rst;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= eentry_rst;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
            tid    <= tid_rst;
        end else if (trap.ex) begin
            // precise trap entry
            prmd[pmode_w-1:0] <= crmd[pmode_w-1:0];  // pplv, pie
            crmd[pmode_w-1:0] <= '0;                 // kernel mode, irq off
            era               <= trap.pc;
            estat[estat_ecode_lsb +: $bits(ecode_e)] <= trap.ecode;
            estat[estat_esub_lsb +: esubcode_w]      <= trap.esubcode;
        end else if (trap.ertn) begin
            crmd[pmode_w-1:0] <= prmd[pmode_w-1:0];
        end else if (csr_req.we) begin
            case (csr_req.num)
                csr_crmd:   crmd    <= wr_merge;
                csr_prmd:   prmd    <= wr_merge;
                csr_estat:  estat   <= wr_merge;
                csr_era:    era     <= wr_merge;
                csr_eentry: eentry  <= wr_merge;
                csr_save0:  save[0] <= wr_merge;
                csr_save1:  save[1] <= wr_merge;
                csr_save2:  save[2] <= wr_merge;
                csr_save3:  save[3] <= wr_merge;
                csr_tid:    tid     <= wr_merge;
                default: ;  // unimplemented, write ignored
            endcase
        end
    end

    // read decode
    always_comb begin
        case (csr_req.num)
            csr_crmd:   rd_mux = crmd;
            csr_prmd:   rd_mux = prmd;
            csr_estat:  rd_mux = estat;
            csr_era:    rd_mux = era;
            csr_eentry: rd_mux = eentry;
            csr_save0:  rd_mux = save[0];
            csr_save1:  rd_mux = save[1];
            csr_save2:  rd_mux = save[2];
            csr_save3:  rd_mux = save[3];
            csr_tid:    rd_mux = tid;
            default:    rd_mux = '0;
        endcase
    end

    assign csr_rvalue = csr_req.re ? rd_mux : '0;
    assign tid_rvalue = tid;

    // redirect during the wb cycle of the event
    assign flush_valid = trap.ex | trap.ertn;
    assign flush_pc    = trap.ex ? eentry : era;

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import la_backend_pkg::*;
(
    input  logic                 clk,

    // read ports, asynchronous
    input  logic [rf_addr_w-1:0] raddr1,
    input  logic [rf_addr_w-1:0] raddr2,
    output logic [xlen-1:0]      rdata1,
    output logic [xlen-1:0]      rdata2,

    // write port from write-back
    input  rf_wr_t               rf_wr
);

    logic [xlen-1:0] regs [rf_depth];

    always_ff @(posedge clk) begin
        if (rf_wr.we && (rf_wr.waddr != '0)) begin
            regs[rf_wr.waddr] <= rf_wr.wdata; // r0 never written
        end
    end

    // r0 reads as zero regardless of array contents
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/la_backend_pkg.sv
package la_backend_pkg;

    // datapath and register file geometry
    localparam int xlen      = 32;
    localparam int rf_addr_w = 5;
    localparam int rf_depth  = 1 << rf_addr_w;

    localparam int esubcode_w = 9;

    // plv[1:0] and ie[2] sit in the low bits of both crmd and prmd
    localparam int pmode_w = 3;

    // estat exception fields
    localparam int estat_ecode_lsb = 16; // ecode is [21:16]
    localparam int estat_esub_lsb  = 22; // esubcode is [30:22]

    // csr reset values
    localparam logic [xlen-1:0] crmd_rst   = 32'h0000_0008; // plv 0, da set
    localparam logic [xlen-1:0] eentry_rst = 32'h1c00_8000;
    localparam logic [xlen-1:0] tid_rst    = 32'h0000_00a5;

    // implemented csr numbers
    typedef enum logic [13:0] {
        csr_crmd   = 14'h000,
        csr_prmd   = 14'h001,
        csr_estat  = 14'h005,
        csr_era    = 14'h006,
        csr_eentry = 14'h00c,
        csr_save0  = 14'h030,
        csr_save1  = 14'h031,
        csr_save2  = 14'h032,
        csr_save3  = 14'h033,
        csr_tid    = 14'h040
    } csr_num_e;

    typedef enum logic [5:0] {
        ecode_adef = 6'h08, // fetch address error
        ecode_ale  = 6'h09, // misaligned load/store
        ecode_sys  = 6'h0b, // syscall
        ecode_brk  = 6'h0c, // break
        ecode_ine  = 6'h0d  // undefined instruction
    } ecode_e;

    // one-hot exception tags carried down the pipe
    typedef struct packed {
        logic adef;
        logic sys;
        logic ale;
        logic brk;
        logic ine;
    } excp_t;

    // one retired instruction from the memory stage
    typedef struct packed {
        logic                  rf_we;
        logic [rf_addr_w-1:0]  rf_waddr;
        logic [xlen-1:0]       rf_wdata;
        logic [xlen-1:0]       pc;
        logic                  read_tid;   // rdcntid
        logic                  csr_re;
        logic                  csr_we;
        csr_num_e              csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [xlen-1:0]       csr_wvalue;
        logic                  ertn;
        excp_t                 excp;
        logic [esubcode_w-1:0] esubcode;
    } mem_to_wb_t;

    typedef struct packed {
        logic                 we;
        logic [rf_addr_w-1:0] waddr;
        logic [xlen-1:0]      wdata;
    } rf_wr_t;

    typedef struct packed {
        logic            re;
        logic            we;
        csr_num_e        num;
        logic [xlen-1:0] wmask;
        logic [xlen-1:0] wvalue;
    } csr_req_t;

    typedef struct packed {
        logic                  ex;
        ecode_e                ecode;
        logic [esubcode_w-1:0] esubcode;
        logic [xlen-1:0]       pc;
        logic                  ertn;
    } trap_t;

    // debug trace, one entry per retired instruction
    typedef struct packed {
        logic [xlen-1:0]      pc;
        logic [3:0]           rf_we;
        logic [rf_addr_w-1:0] rf_wnum;
        logic [xlen-1:0]      rf_wdata;
    } trace_t;

endpackage
